//--- Bender.yml
package:
  name: radio_ctrl_core

sources:
  - common/core_pkg.sv
  - logic/setting_reg.sv
  - logic/ctrl_regs.sv
  - timekeeper/vita_time.sv
  - logic/readback_mux.sv
  - logic/radio_ctrl_core.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/radio_ctrl_tb.sv

//--- common/core_pkg.sv
/* Settings map, readback indices and shared types of the radio control core.
   Settings addresses are register indices on the 8-bit settings bus */
`default_nettype none

package core_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and payload types
   typedef logic [7:0]  set_addr_t;    // Settings bus address
   typedef logic [31:0] set_data_t;    // Settings bus data
   typedef logic [3:0]  rb_addr_t;     // Readback word index
   typedef logic [31:0] rb_word_t;     // Readback word
   typedef logic [63:0] vita_time_t;   // VITA time in ticks
   typedef logic [7:0]  ctrl_byte_t;   // One misc control register

   ////////////////////////////////////////////////////////////////////////////
   // Settings register bases
   // Misc offsets: 0 clock, 1 SERDES, 2 ADC, 3 sw LEDs, 4 PHY reset, 6 LED source
   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd10;   // +0 staged hi, +1 lo and load
   localparam set_addr_t SR_DIVSW  = 8'd180;  // Two diversity switches

   // Bump when the register map changes
   localparam rb_word_t COMPAT_NUM = {16'd8, 16'd2};   // Major, minor

   // Bit set means the LED shows hardware status
   localparam ctrl_byte_t LED_SRC_AT_RESET = 8'b0001_1110;

   ////////////////////////////////////////////////////////////////////////////
   // Readback word indices, lower words read as zero
   localparam rb_addr_t RB_TIME_HI = 4'd10;
   localparam rb_addr_t RB_TIME_LO = 4'd11;
   localparam rb_addr_t RB_COMPAT  = 4'd12;
   localparam rb_addr_t RB_FLAGS   = 4'd13;
   localparam rb_addr_t RB_PPS_HI  = 4'd14;
   localparam rb_addr_t RB_PPS_LO  = 4'd15;

endpackage

`default_nettype wire

//--- dv/radio_ctrl_tb.sv
/* Directed tests of radio_ctrl_core. Inputs change on the rising edge and
   outputs are sampled on the falling edge */
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_tb;

   import core_pkg::*;

   localparam int          CLK_PERIOD  = 8;
   localparam int          TEST_CYCLES = 200;   // All six tests, rounded up
   localparam int          TIMEOUT_NS  = 2 * TEST_CYCLES * CLK_PERIOD;
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

   logic       dsp_clk, por_rst;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic [1:0] run_rx_i;
   logic       run_tx_i, clk_status_i, serdes_link_up_i, button_i, pps_i;
   rb_addr_t   rb_addr_i;
   rb_word_t   rb_data_o;
   logic       clock_ready_o, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic [1:0] clk_en_o, clk_sel_o, div_sw_o;
   logic       adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_reset_n_o, pps_int_o;
   ctrl_byte_t leds_o;

   logic [31:0] lfsr_state;
   int          checks = 0;
   int          errors = 0;

   tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) clock_gen (
      .dsp_clk_o(dsp_clk), .por_rst_o(por_rst));

   radio_ctrl_core dut (.*);

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   function automatic logic [63:0] rand_bits(input int unsigned n);
      logic [63:0] v;
      logic        b;
      int unsigned i;
      v = '0;
      for (i = 0; i < n; i++) begin
         b = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (b)
            lfsr_state = lfsr_state ^ LFSR_TAPS;
         v = {v[62:0], b};
      end
      return v;
   endfunction

   // Hardware bit where the source bit is set, software bit elsewhere
   function automatic ctrl_byte_t led_model(input ctrl_byte_t sw, input ctrl_byte_t src,
                                            input logic tx, input logic [1:0] rx,
                                            input logic clk_ok, input logic link_ok);
      ctrl_byte_t hw;
      ctrl_byte_t led;
      int         i;
      hw    = 8'h00;
      hw[4] = tx;
      hw[3] = rx[0] | rx[1];
      hw[2] = clk_ok;
      hw[1] = link_ok;
      for (i = 0; i < 8; i++)
         led[i] = src[i] ? hw[i] : sw[i];
      return led;
   endfunction

   // {clock, SERDES, ADC, PHY reset_n, switches}
   function automatic logic [15:0] ctrl_state();
      return {clock_ready_o, clk_en_o, clk_sel_o, ser_enable_o, ser_prbsen_o, ser_loopen_o,
              ser_rx_en_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_reset_n_o,
              div_sw_o};
   endfunction

   task automatic compare(input string test, input string what,
                          input logic [63:0] expected, input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error %s %s: expected %h actual %h", test, what, expected, actual);
      end
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge dsp_clk);     // Register takes the value here
      set_stb_i  <= 1'b0;
   endtask

   // Address goes out on the next edge, data is valid after the one after
   task automatic read_word(input rb_addr_t addr, output rb_word_t data);
      @(posedge dsp_clk);
      rb_addr_i <= addr;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   task automatic write_and_check(input set_addr_t addr, input set_data_t data,
                                  input logic [15:0] expected, input string what);
      write_setting(addr, data);
      @(negedge dsp_clk);
      compare("control_writes", what, 64'(expected), 64'(ctrl_state()));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   task automatic reset_defaults();
      rb_word_t word;
      @(negedge dsp_clk);
      compare("reset_defaults", "control lines", 64'h0007, 64'(ctrl_state()));
      compare("reset_defaults", "leds_o", 64'd0, 64'(leds_o));
      compare("reset_defaults", "pps_int_o", 64'd0, 64'(pps_int_o));
      read_word(RB_COMPAT, word);
      compare("reset_defaults", "compat word", 64'({16'd8, 16'd2}), 64'(word));
      // Hardware levels high, source mask at reset passes bits 4..2
      @(posedge dsp_clk);
      run_rx_i     <= 2'b11;
      run_tx_i     <= 1'b1;
      clk_status_i <= 1'b1;
      repeat (2) @(negedge dsp_clk);
      compare("reset_defaults", "leds_o source mask",
              64'(led_model(8'h00, 8'b0001_1110, 1'b1, 2'b11, 1'b1, 1'b0)), 64'(leds_o));
      @(posedge dsp_clk);
      run_rx_i     <= 2'b00;
      run_tx_i     <= 1'b0;
      clk_status_i <= 1'b0;
   endtask

   task automatic control_writes();
      set_data_t   data;
      logic [15:0] expected;
      int          round;
      expected = 16'h0007;
      for (round = 0; round < 3; round++) begin
         data = 32'(rand_bits(32));
         expected[15:11] = data[4:0];
         write_and_check(SR_MISC, data, expected, "clock register");
         data = 32'(rand_bits(32));
         expected[10:7] = data[3:0];
         write_and_check(SR_MISC + 8'd1, data, expected, "SERDES register");
         data = 32'(rand_bits(32));
         expected[6:3] = data[3:0];
         write_and_check(SR_MISC + 8'd2, data, expected, "ADC register");
         data = 32'(rand_bits(32));
         expected[2] = ~data[0];   // Register bit is an active high reset
         write_and_check(SR_MISC + 8'd4, data, expected, "PHY reset");
         data = 32'(rand_bits(32));
         expected[0] = data[0];
         write_and_check(SR_DIVSW, data, expected, "switch 0");
         data = 32'(rand_bits(32));
         expected[1] = data[0];
         write_and_check(SR_DIVSW + 8'd1, data, expected, "switch 1");
         write_and_check(SR_MISC + 8'd5, 32'(rand_bits(32)), expected, "unused 5");
         write_and_check(8'd200, 32'(rand_bits(32)), expected, "unused 200");
      end
   endtask

   task automatic led_mixing();
      ctrl_byte_t sw, src;
      logic [1:0] rx, rx_old;
      logic       tx, tx_old, clk_ok, link;
      int         step;
      rx_old = 2'b00;
      tx_old = 1'b0;
      for (step = 0; step < 4; step++) begin
         sw  = 8'(rand_bits(8));
         src = 8'(rand_bits(8));
         {rx, tx, clk_ok, link} = 5'(rand_bits(5));
         write_setting(SR_MISC + 8'd3, sw);
         write_setting(SR_MISC + 8'd6, src);
         run_rx_i         <= rx;
         run_tx_i         <= tx;
         clk_status_i     <= clk_ok;
         serdes_link_up_i <= link;
         // No PPS yet, so the link bit sees good_sync low
         @(negedge dsp_clk);
         compare("led_mixing", "leds_o old run", 64'(led_model(sw, src, tx_old, rx_old,
                 clk_ok, 1'b0)), 64'(leds_o));
         @(negedge dsp_clk);
         compare("led_mixing", "leds_o new run", 64'(led_model(sw, src, tx, rx,
                 clk_ok, 1'b0)), 64'(leds_o));
         rx_old = rx;
         tx_old = tx;
      end
   endtask

   task automatic time_load_readback();
      vita_time_t load;
      rb_word_t   word;
      load = rand_bits(64);
      write_setting(SR_TIME64, load[63:32]);
      write_setting(SR_TIME64 + 8'd1, load[31:0]);   // Counter holds load from here
      repeat (4) @(posedge dsp_clk);
      read_word(RB_TIME_HI, word);
      compare("time_load_readback", "time high", 64'(load + 64'd5 >> 32), 64'(word));
      read_word(RB_TIME_LO, word);
      compare("time_load_readback", "time low", 64'(32'(load + 64'd7)), 64'(word));
   endtask

   task automatic pps_capture();
      vita_time_t load, capture;
      rb_word_t   word;
      int         cyc;
      load = rand_bits(64);
      write_setting(SR_MISC + 8'd6, 32'h0000_0002);   // LED bit 1 from hardware
      write_setting(SR_TIME64, load[63:32]);
      write_setting(SR_TIME64 + 8'd1, load[31:0]);
      serdes_link_up_i <= 1'b1;
      repeat (3) @(posedge dsp_clk);
      pps_i <= 1'b1;
      capture = load + 64'd5;   // 3 cycles to the PPS edge plus 2 sync stages
      for (cyc = 0; cyc < 6; cyc++) begin
         @(negedge dsp_clk);
         compare("pps_capture", $sformatf("pps_int_o cycle %0d", cyc), 64'(cyc == 3),
                 64'(pps_int_o));
         if (cyc == 0)
            compare("pps_capture", "led 1 before sync", 64'd0, 64'(leds_o[1]));
      end
      compare("pps_capture", "led 1 after sync", 64'd1, 64'(leds_o[1]));
      @(posedge dsp_clk);
      pps_i <= 1'b0;
      read_word(RB_PPS_HI, word);
      compare("pps_capture", "capture high", 64'(capture[63:32]), 64'(word));
      read_word(RB_PPS_LO, word);
      compare("pps_capture", "capture low", 64'(capture[31:0]), 64'(word));
   endtask

   task automatic status_flags();
      rb_word_t   word, expected;
      logic [2:0] lv;
      int         idx;
      for (idx = 0; idx < 8; idx++) begin
         lv = 3'(idx);
         @(posedge dsp_clk);
         button_i         <= lv[2];
         clk_status_i     <= lv[1];
         serdes_link_up_i <= lv[0];
         expected     = '0;
         expected[13] = lv[2];
         expected[11] = lv[1];
         expected[10] = lv[0];
         read_word(RB_FLAGS, word);
         compare("status_flags", "flags word", 64'(expected), 64'(word));
      end
      for (idx = 0; idx < 10; idx++) begin
         read_word(rb_addr_t'(idx), word);
         compare("status_flags", $sformatf("word %0d", idx), 64'd0, 64'(word));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence and watchdog
   initial begin
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      run_rx_i         = 2'b00;
      run_tx_i         = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      button_i         = 1'b0;
      pps_i            = 1'b0;
      rb_addr_i        = '0;
      lfsr_state       = 32'hc43e_f54c;
      do
         @(posedge dsp_clk);
      while (por_rst);
      reset_defaults();
      control_writes();
      led_mixing();
      time_load_readback();
      pps_capture();
      status_flags();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
/* Testbench clock and power-on reset. Reset is released on the rising edge
   that ends the last reset cycle */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 2
) (
   output logic dsp_clk_o,
   output logic por_rst_o
);

   initial begin
      dsp_clk_o = 1'b0;
      forever #(PERIOD_NS / 2) dsp_clk_o = ~dsp_clk_o;
   end

   initial begin
      por_rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge dsp_clk_o);
      por_rst_o <= 1'b0;
   end

endmodule

`default_nettype wire

//--- logic/ctrl_regs.sv
/* Misc control registers and LED source mixing. Outputs follow their register
   one cycle after the write strobe; leds_o is combinational from registers */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
   input  wire logic                dsp_clk,
   input  wire logic                por_rst,
   input  wire logic                set_stb_i,
   input  wire core_pkg::set_addr_t set_addr_i,
   input  wire core_pkg::set_data_t set_data_i,
   input  wire logic [1:0]          run_rx_i,
   input  wire logic                run_tx_i,
   input  wire logic                clk_status_i,
   input  wire logic                serdes_link_up_i,
   input  wire logic                good_sync_i,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_reset_n_o,
   output logic [1:0]               div_sw_o,
   output core_pkg::ctrl_byte_t     leds_o
);

   import core_pkg::*;

   ctrl_byte_t clock_outs, serdes_outs, adc_outs;
   ctrl_byte_t led_sw, led_src, led_hw;
   logic       phy_reset;
   logic [1:0] run_rx_d1;
   logic       run_tx_d1;

   ////////////////////////////////////////////////////////////////////////////
   // Byte wide registers
   setting_reg #(.MY_ADDR(SR_MISC + 8'd0), .payload_t(ctrl_byte_t), .AT_RESET(8'h00)) sr_clk (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(clock_outs), .changed_o());

   setting_reg #(.MY_ADDR(SR_MISC + 8'd1), .payload_t(ctrl_byte_t), .AT_RESET(8'h00)) sr_ser (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(serdes_outs), .changed_o());

   setting_reg #(.MY_ADDR(SR_MISC + 8'd2), .payload_t(ctrl_byte_t), .AT_RESET(8'h00)) sr_adc (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(adc_outs), .changed_o());

   setting_reg #(.MY_ADDR(SR_MISC + 8'd3), .payload_t(ctrl_byte_t), .AT_RESET(8'h00)) sr_led (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(led_sw), .changed_o());

   setting_reg #(.MY_ADDR(SR_MISC + 8'd6), .payload_t(ctrl_byte_t),
                 .AT_RESET(LED_SRC_AT_RESET)) sr_led_src (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(led_src), .changed_o());

   // Single bit registers, switches come up closed
   setting_reg #(.MY_ADDR(SR_MISC + 8'd4), .payload_t(logic), .AT_RESET(1'b0)) sr_phy (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(phy_reset), .changed_o());

   setting_reg #(.MY_ADDR(SR_DIVSW + 8'd0), .payload_t(logic), .AT_RESET(1'b1)) sr_divsw1 (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(div_sw_o[0]), .changed_o());

   setting_reg #(.MY_ADDR(SR_DIVSW + 8'd1), .payload_t(logic), .AT_RESET(1'b1)) sr_divsw2 (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(div_sw_o[1]), .changed_o());

   assign {clock_ready_o, clk_en_o, clk_sel_o}                     = clock_outs[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}  = serdes_outs[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}         = adc_outs[3:0];
   assign phy_reset_n_o = ~phy_reset;   // Register holds active high reset

   ////////////////////////////////////////////////////////////////////////////
   // LEDs, source bit 1 selects hardware status
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_rx_d1 <= 2'b00;
         run_tx_d1 <= 1'b0;
      end else begin
         run_rx_d1 <= run_rx_i;
         run_tx_d1 <= run_tx_i;
      end
   end

   assign led_hw = {3'b000, run_tx_d1, |run_rx_d1, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

//--- logic/radio_ctrl_core.sv
/* Control plane of the radio core, all on dsp_clk. Settings writes are single
   cycle strobes with no acknowledge */
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_core (
   input  wire logic                dsp_clk,
   input  wire logic                por_rst,
   // Settings bus
   input  wire logic                set_stb_i,
   input  wire core_pkg::set_addr_t set_addr_i,
   input  wire core_pkg::set_data_t set_data_i,
   // Status levels
   input  wire logic [1:0]          run_rx_i,
   input  wire logic                run_tx_i,
   input  wire logic                clk_status_i,
   input  wire logic                serdes_link_up_i,
   input  wire logic                button_i,
   input  wire logic                pps_i,
   // Readback
   input  wire core_pkg::rb_addr_t  rb_addr_i,
   output core_pkg::rb_word_t       rb_data_o,
   // Control lines
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_reset_n_o,
   output logic [1:0]               div_sw_o,
   output core_pkg::ctrl_byte_t     leds_o,
   output logic                     pps_int_o
);

   import core_pkg::*;

   vita_time_t time_now;
   vita_time_t time_pps;
   logic       good_sync;

   ctrl_regs ctrl_regs (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .run_rx_i, .run_tx_i, .clk_status_i, .serdes_link_up_i,
      .good_sync_i(good_sync),
      .clock_ready_o, .clk_en_o, .clk_sel_o,
      .ser_enable_o, .ser_prbsen_o, .ser_loopen_o, .ser_rx_en_o,
      .adc_oe_a_o, .adc_on_a_o, .adc_oe_b_o, .adc_on_b_o,
      .phy_reset_n_o, .div_sw_o, .leds_o);

   vita_time vita_time (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i, .pps_i,
      .vita_time_o(time_now), .vita_time_pps_o(time_pps),
      .pps_int_o, .good_sync_o(good_sync));

   readback_mux readback_mux (
      .dsp_clk, .por_rst, .rb_addr_i,
      .vita_time_i(time_now), .vita_time_pps_i(time_pps),
      .button_i, .clk_status_i, .serdes_link_up_i,
      .rb_data_o);

endmodule

`default_nettype wire

//--- logic/readback_mux.sv
/* Registered status readback, data follows the address by one clock.
   Words below RB_TIME_HI read as zero */
`timescale 1ns/1ps
`default_nettype none

module readback_mux (
   input  wire logic                 dsp_clk,
   input  wire logic                 por_rst,
   input  wire core_pkg::rb_addr_t   rb_addr_i,
   input  wire core_pkg::vita_time_t vita_time_i,
   input  wire core_pkg::vita_time_t vita_time_pps_i,
   input  wire logic                 button_i,
   input  wire logic                 clk_status_i,
   input  wire logic                 serdes_link_up_i,
   output core_pkg::rb_word_t        rb_data_o
);

   import core_pkg::*;

   rb_word_t flags;

   // Button at 13, clock status at 11, SERDES link at 10
   assign flags = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            RB_TIME_HI : rb_data_o <= vita_time_i[63:32];
            RB_TIME_LO : rb_data_o <= vita_time_i[31:0];
            RB_COMPAT  : rb_data_o <= COMPAT_NUM;
            RB_FLAGS   : rb_data_o <= flags;
            RB_PPS_HI  : rb_data_o <= vita_time_pps_i[63:32];
            RB_PPS_LO  : rb_data_o <= vita_time_pps_i[31:0];
            default    : rb_data_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/setting_reg.sv
/* Single settings register. Payload is taken from the low bits of the data word,
   so payload_t must be packed and at most 32 bits wide */
`timescale 1ns/1ps
`default_nettype none

module setting_reg #(
   parameter core_pkg::set_addr_t MY_ADDR  = '0,
   parameter type                 payload_t = logic [7:0],
   parameter payload_t            AT_RESET  = '0
) (
   input  wire logic                dsp_clk,
   input  wire logic                por_rst,
   input  wire logic                set_stb_i,
   input  wire core_pkg::set_addr_t set_addr_i,
   input  wire core_pkg::set_data_t set_data_i,
   output payload_t                 out_o,
   output logic                     changed_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         out_o     <= AT_RESET;
         changed_o <= 1'b0;
      end else if (hit) begin
         out_o     <= set_data_i[$bits(payload_t)-1:0];
         changed_o <= 1'b1;   // One cycle, same cycle as new value
      end else begin
         changed_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- sources.f
common/core_pkg.sv
logic/setting_reg.sv
logic/ctrl_regs.sv
timekeeper/vita_time.sv
logic/readback_mux.sv
logic/radio_ctrl_core.sv
dv/tb_clock.sv
dv/radio_ctrl_tb.sv

//--- timekeeper/vita_time.sv
/* 64-bit tick counter. Writing the low word loads the counter with the staged
   high word; pps_i is asynchronous and must stay high for at least 2 clocks */
`timescale 1ns/1ps
`default_nettype none

module vita_time (
   input  wire logic                dsp_clk,
   input  wire logic                por_rst,
   input  wire logic                set_stb_i,
   input  wire core_pkg::set_addr_t set_addr_i,
   input  wire core_pkg::set_data_t set_data_i,
   input  wire logic                pps_i,
   output core_pkg::vita_time_t     vita_time_o,
   output core_pkg::vita_time_t     vita_time_pps_o,
   output logic                     pps_int_o,
   output logic                     good_sync_o
);

   import core_pkg::*;

   set_data_t  time_hi;   // Staged upper word
   logic       hi_wr, lo_wr;
   logic [1:0] pps_sync;
   logic       pps_d;
   logic       pps_edge;

   assign hi_wr = set_stb_i && (set_addr_i == SR_TIME64);
   assign lo_wr = set_stb_i && (set_addr_i == SR_TIME64 + 8'd1);

   always_ff @(posedge dsp_clk) begin
      if (hi_wr)
         time_hi <= set_data_i;
   end

   // Counter, load takes the place of one increment
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         vita_time_o <= '0;
      else if (lo_wr)
         vita_time_o <= {time_hi, set_data_i};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and edge detect
   assign pps_edge = pps_sync[1] & ~pps_d;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync  <= 2'b00;
         pps_d     <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_sync  <= {pps_sync[0], pps_i};
         pps_d     <= pps_sync[1];
         pps_int_o <= pps_edge;   // Single cycle interrupt
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         vita_time_pps_o <= '0;
      else if (pps_edge)
         vita_time_pps_o <= vita_time_o;
   end

   // Time is only trusted once a PPS arrived after the last load
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         good_sync_o <= 1'b0;
      else if (lo_wr)
         good_sync_o <= 1'b0;
      else if (pps_edge)
         good_sync_o <= 1'b1;
   end

endmodule

`default_nettype wire
